//--- include/ps2_settings.svh
`ifndef PS2_SETTINGS_SVH
`define PS2_SETTINGS_SVH

// Prefix sent ahead of the make code when a key is released
`define PS2_BREAK_CODE 8'hF0

// Player one keys
`define PS2_CODE_E 8'h24
`define PS2_CODE_W 8'h1D
`define PS2_CODE_A 8'h1C
`define PS2_CODE_S 8'h1B
`define PS2_CODE_D 8'h23

// Player two keys, all on the keypad
`define PS2_CODE_KP7 8'h6C
`define PS2_CODE_KP8 8'h75
`define PS2_CODE_KP4 8'h6B
`define PS2_CODE_KP5 8'h73
`define PS2_CODE_KP6 8'h74

// Number of tracked game keys
`define PS2_KEY_COUNT 10

// Bus read data width
`define PS2_BUS_WIDTH 32

// Parity error counter, saturates at all ones
`define PS2_ERR_WIDTH 8
`define PS2_ERR_ADDR 10

`endif

//--- verilog/ps2_pkg.sv
package ps2_pkg;

    // Key index, also the bus address of that key's pressed bit
    // 0..4 = E W A S D, 5..9 = KP7 KP8 KP4 KP5 KP6
    typedef logic [3:0] key_id_t;

    localparam key_id_t KEY_E   = 4'd0;
    localparam key_id_t KEY_W   = 4'd1;
    localparam key_id_t KEY_A   = 4'd2;
    localparam key_id_t KEY_S   = 4'd3;
    localparam key_id_t KEY_D   = 4'd4;
    localparam key_id_t KEY_KP7 = 4'd5;
    localparam key_id_t KEY_KP8 = 4'd6;
    localparam key_id_t KEY_KP4 = 4'd7;
    localparam key_id_t KEY_KP5 = 4'd8;
    localparam key_id_t KEY_KP6 = 4'd9;

    // One received byte and its parity check result
    typedef struct packed {
        logic [7:0] code;
        logic       parity_ok;
    } ps2_frame_t;

    // Press or release of one game key
    typedef struct packed {
        key_id_t key;
        logic    pressed;
    } key_event_t;

endpackage

//--- verilog/ps2_sync.sv
`timescale 1ns/1ps

module ps2_sync (
    input  logic clk,
    input  logic rst_n,
    input  logic ps2_clk_pin,
    input  logic ps2_data_pin,
    output logic fall,
    output logic data_bit
);

    logic clk_s1;
    logic clk_s2;
    logic clk_prev;
    logic data_s1;
    logic data_s2;

    // Both lines idle high, so the flops come out of reset at 1
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            clk_s1   <= 1'b1;
            clk_s2   <= 1'b1;
            clk_prev <= 1'b1;
            data_s1  <= 1'b1;
            data_s2  <= 1'b1;
            fall     <= 1'b0;
            data_bit <= 1'b1;
        end else begin
            clk_s1   <= ps2_clk_pin;
            clk_s2   <= clk_s1;
            clk_prev <= clk_s2;
            data_s1  <= ps2_data_pin;
            data_s2  <= data_s1;
            // Edge detect is registered, so fall shows up 3 cycles after the pin
            fall     <= clk_prev & ~clk_s2;
            // Data kept aligned with the fall strobe
            data_bit <= data_s2;
        end
    end

endmodule

//--- verilog/ps2_frame_rx.sv
`timescale 1ns/1ps

module ps2_frame_rx import ps2_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       fall,
    input  logic       data_bit,
    output logic       frame_valid,
    output ps2_frame_t frame
);

    // bit_cnt 0 waits for start, 1..8 data, 9 parity, 10 stop
    logic [3:0] bit_cnt;
    logic [7:0] shreg;
    logic       parity_bit;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bit_cnt     <= 4'd0;
            frame_valid <= 1'b0;
        end else begin
            frame_valid <= 1'b0;
            if (fall) begin
                if (bit_cnt == 4'd0) begin
                    // A high start bit is not a frame, keep hunting
                    if (!data_bit) begin
                        bit_cnt <= 4'd1;
                    end
                end else if (bit_cnt == 4'd10) begin
                    bit_cnt     <= 4'd0;
                    // Frame only counts if the stop bit is high
                    frame_valid <= data_bit;
                end else begin
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fall) begin
            // LSB arrives first
            if (bit_cnt >= 4'd1 && bit_cnt <= 4'd8) begin
                shreg <= {data_bit, shreg[7:1]};
            end
            if (bit_cnt == 4'd9) begin
                parity_bit <= data_bit;
            end
            if (bit_cnt == 4'd10) begin
                frame.code      <= shreg;
                // Odd parity over data plus parity bit
                frame.parity_ok <= ^{shreg, parity_bit};
            end
        end
    end

endmodule

//--- verilog/scan_filter.sv
`timescale 1ns/1ps

`include "ps2_settings.svh"

module scan_filter import ps2_pkg::*; (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      frame_valid,
    input  ps2_frame_t                frame,
    output logic                      ev_valid,
    output key_event_t                ev,
    output logic [`PS2_ERR_WIDTH-1:0] err_count
);

    logic    brk;
    logic    is_game;
    key_id_t game_id;

    // Game code lookup
    always_comb begin
        is_game = 1'b1;
        game_id = KEY_E;
        case (frame.code)
            `PS2_CODE_E:   game_id = KEY_E;
            `PS2_CODE_W:   game_id = KEY_W;
            `PS2_CODE_A:   game_id = KEY_A;
            `PS2_CODE_S:   game_id = KEY_S;
            `PS2_CODE_D:   game_id = KEY_D;
            `PS2_CODE_KP7: game_id = KEY_KP7;
            `PS2_CODE_KP8: game_id = KEY_KP8;
            `PS2_CODE_KP4: game_id = KEY_KP4;
            `PS2_CODE_KP5: game_id = KEY_KP5;
            `PS2_CODE_KP6: game_id = KEY_KP6;
            default:       is_game = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            brk       <= 1'b0;
            ev_valid  <= 1'b0;
            err_count <= '0;
        end else begin
            ev_valid <= 1'b0;
            if (frame_valid) begin
                if (!frame.parity_ok) begin
                    // Bad frame, break state untouched
                    if (err_count != '1) begin
                        err_count <= err_count + 1'b1;
                    end
                end else if (frame.code == `PS2_BREAK_CODE) begin
                    brk <= 1'b1;
                end else begin
                    ev_valid <= is_game;
                    brk      <= 1'b0;
                end
            end
        end
    end

    // Event payload, qualified by ev_valid
    always_ff @(posedge clk) begin
        if (frame_valid) begin
            ev.key     <= game_id;
            ev.pressed <= ~brk;
        end
    end

endmodule

//--- verilog/key_state.sv
`timescale 1ns/1ps

`include "ps2_settings.svh"

module key_state import ps2_pkg::*; (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      ev_valid,
    input  key_event_t                ev,
    output logic [`PS2_KEY_COUNT-1:0] keys
);

    // One bit per game key, set on make and cleared on break
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            keys <= '0;
        end else if (ev_valid) begin
            keys[ev.key] <= ev.pressed;
        end
    end

endmodule

//--- verilog/bus_read_port.sv
`timescale 1ns/1ps

`include "ps2_settings.svh"

module bus_read_port (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      rd,
    input  logic [3:0]                addr,
    input  logic [`PS2_KEY_COUNT-1:0] keys,
    input  logic [`PS2_ERR_WIDTH-1:0] err_count,
    output logic                      rd_valid,
    output logic [`PS2_BUS_WIDTH-1:0] rd_data
);

    logic [`PS2_BUS_WIDTH-1:0] rd_word;

    // Address decode, unmapped addresses read zero
    always_comb begin
        rd_word = '0;
        if (addr < 4'(`PS2_KEY_COUNT)) begin
            rd_word[0] = keys[addr];
        end else if (addr == 4'(`PS2_ERR_ADDR)) begin
            rd_word[`PS2_ERR_WIDTH-1:0] = err_count;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd;
        end
    end

    // Data is held until the next read
    always_ff @(posedge clk) begin
        if (rd) begin
            rd_data <= rd_word;
        end
    end

endmodule

//--- verilog/ps2_controller.sv
`timescale 1ns/1ps

`include "ps2_settings.svh"

module ps2_controller import ps2_pkg::*; (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      ps2_clk_pin,
    input  logic                      ps2_data_pin,
    input  logic                      rd,
    input  logic [3:0]                addr,
    output logic                      rd_valid,
    output logic [`PS2_BUS_WIDTH-1:0] rd_data
);

    logic                      fall;
    logic                      data_bit;
    logic                      frame_valid;
    ps2_frame_t                frame;
    logic                      ev_valid;
    key_event_t                ev;
    logic [`PS2_ERR_WIDTH-1:0] err_count;
    logic [`PS2_KEY_COUNT-1:0] keys;

    // PS/2 pins into the clk domain
    ps2_sync u_sync (
        .clk          (clk),
        .rst_n        (rst_n),
        .ps2_clk_pin  (ps2_clk_pin),
        .ps2_data_pin (ps2_data_pin),
        .fall         (fall),
        .data_bit     (data_bit)
    );

    ps2_frame_rx u_frame_rx (
        .clk         (clk),
        .rst_n       (rst_n),
        .fall        (fall),
        .data_bit    (data_bit),
        .frame_valid (frame_valid),
        .frame       (frame)
    );

    // Make/break decoding and parity error count
    scan_filter u_scan_filter (
        .clk         (clk),
        .rst_n       (rst_n),
        .frame_valid (frame_valid),
        .frame       (frame),
        .ev_valid    (ev_valid),
        .ev          (ev),
        .err_count   (err_count)
    );

    key_state u_key_state (
        .clk      (clk),
        .rst_n    (rst_n),
        .ev_valid (ev_valid),
        .ev       (ev),
        .keys     (keys)
    );

    bus_read_port u_bus_read_port (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd        (rd),
        .addr      (addr),
        .keys      (keys),
        .err_count (err_count),
        .rd_valid  (rd_valid),
        .rd_data   (rd_data)
    );

endmodule

//--- bench/ps2_controller_props.sv
`timescale 1ns/1ps

`include "ps2_settings.svh"

module ps2_controller_props (
    input logic                      clk,
    input logic                      rst_n,
    input logic                      rd,
    input logic                      rd_valid,
    input logic                      fall,
    input logic                      frame_valid,
    input logic                      ev_valid,
    input logic [`PS2_KEY_COUNT-1:0] keys,
    input logic [`PS2_ERR_WIDTH-1:0] err_count
);

    // Read answered exactly one cycle later, and only then
    rd_answered: assert property (@(posedge clk) disable iff (!rst_n) rd |=> rd_valid)
        else $error("rd_valid missing one cycle after rd");
    rd_no_stray: assert property (@(posedge clk) disable iff (!rst_n) !rd |=> !rd_valid)
        else $error("rd_valid high without a read one cycle before");

    // Pipeline strobes last a single cycle
    fall_single: assert property (@(posedge clk) disable iff (!rst_n) fall |=> !fall)
        else $error("fall high for two cycles in a row");
    frame_single: assert property (@(posedge clk) disable iff (!rst_n)
                                   frame_valid |=> !frame_valid)
        else $error("frame_valid high for two cycles in a row");
    ev_single: assert property (@(posedge clk) disable iff (!rst_n) ev_valid |=> !ev_valid)
        else $error("ev_valid high for two cycles in a row");

    reset_clear: assert property (@(posedge clk)
                                  (!rst_n && !$past(rst_n)) |-> (keys == '0 && err_count == '0))
        else $error("key bits or error count not zero during reset");

endmodule

bind ps2_controller ps2_controller_props u_props (
    .clk         (clk),
    .rst_n       (rst_n),
    .rd          (rd),
    .rd_valid    (rd_valid),
    .fall        (fall),
    .frame_valid (frame_valid),
    .ev_valid    (ev_valid),
    .keys        (keys),
    .err_count   (err_count)
);

//--- bench/ps2_controller_tb.sv
`timescale 1ns/1ps

`include "ps2_settings.svh"

module ps2_controller_tb;

    localparam int HALF_CYCLES = 8;
    localparam int RAND_STEPS  = 16;

    // One table row: up to two scan bytes, then a read and its expected word
    typedef struct packed {
        logic [1:0]  n_bytes;
        logic [7:0]  byte0;
        logic        bad0;
        logic [7:0]  byte1;
        logic        bad1;
        logic [3:0]  addr;
        logic [31:0] expected;
    } entry_t;

    logic                      clk;
    logic                      rst_n;
    logic                      ps2_clk_pin;
    logic                      ps2_data_pin;
    logic                      rd;
    logic [3:0]                addr;
    logic                      rd_valid;
    logic [`PS2_BUS_WIDTH-1:0] rd_data;

    entry_t     table_q[$];
    string      name_q[$];
    logic [7:0] key_codes [0:9];
    logic [9:0] ref_keys;
    integer     seed;
    int         n_run;
    int         n_failed;
    bit         test_ok;
    bit         table_ready;

    ps2_controller u_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .ps2_clk_pin  (ps2_clk_pin),
        .ps2_data_pin (ps2_data_pin),
        .rd           (rd),
        .addr         (addr),
        .rd_valid     (rd_valid),
        .rd_data      (rd_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst_n <= 1'b0;
        wait_cycles(4);
        rst_n <= 1'b1;
        wait_cycles(2);
    endtask

    // Start bit, eight data bits LSB first, odd parity, stop bit
    task automatic send_frame(input logic [7:0] code, input logic bad_parity);
        logic [10:0] bits;
        logic        parity;
        parity = (~^code) ^ bad_parity;
        bits   = {1'b1, parity, code, 1'b0};
        for (int i = 0; i < 11; i++) begin
            @(posedge clk);
            ps2_data_pin <= bits[i];
            wait_cycles(HALF_CYCLES);
            ps2_clk_pin <= 1'b0;
            wait_cycles(HALF_CYCLES);
            ps2_clk_pin <= 1'b1;
        end
        ps2_data_pin <= 1'b1;
    endtask

    // Data is taken at the falling edge, mid-cycle
    task automatic read_addr(input logic [3:0] a, output logic [31:0] data);
        @(posedge clk);
        rd   <= 1'b1;
        addr <= a;
        @(posedge clk);
        rd <= 1'b0;
        @(negedge clk);
        data = rd_data;
        if (rd_valid !== 1'b1) begin
            $display("Read of address %0d got no rd_valid on the cycle after rd", a);
            test_ok = 1'b0;
        end
    endtask

    task automatic check_read(input string name, input logic [3:0] a,
                              input logic [31:0] expected);
        logic [31:0] got;
        read_addr(a, got);
        if (got !== expected) begin
            $display("Mismatch %s: addr %0d expected 0x%08h actual 0x%08h",
                     name, a, expected, got);
            test_ok = 1'b0;
        end
    endtask

    task automatic finish_test(input string name);
        n_run++;
        if (test_ok) begin
            $display("test %-28s passed", name);
        end else begin
            n_failed++;
            $display("test %-28s failed", name);
        end
    endtask

    function automatic void add_test(input string name, input logic [1:0] n,
                                     input logic [7:0] b0, input logic bad0,
                                     input logic [7:0] b1, input logic bad1,
                                     input logic [3:0] a, input logic [31:0] expected);
        table_q.push_back(entry_t'{n, b0, bad0, b1, bad1, a, expected});
        name_q.push_back(name);
    endfunction

    function automatic void build_table();
        // Each key pressed in turn
        add_test("press_e",            1, `PS2_CODE_E,     0, 8'h00,        0, 0, 1);
        add_test("w_clear_after_e",    0, 8'h00,           0, 8'h00,        0, 1, 0);
        add_test("press_w",            1, `PS2_CODE_W,     0, 8'h00,        0, 1, 1);
        add_test("press_a",            1, `PS2_CODE_A,     0, 8'h00,        0, 2, 1);
        add_test("press_s",            1, `PS2_CODE_S,     0, 8'h00,        0, 3, 1);
        add_test("press_d",            1, `PS2_CODE_D,     0, 8'h00,        0, 4, 1);
        add_test("kp6_clear_before",   0, 8'h00,           0, 8'h00,        0, 9, 0);
        add_test("press_kp7",          1, `PS2_CODE_KP7,   0, 8'h00,        0, 5, 1);
        add_test("press_kp8",          1, `PS2_CODE_KP8,   0, 8'h00,        0, 6, 1);
        add_test("press_kp4",          1, `PS2_CODE_KP4,   0, 8'h00,        0, 7, 1);
        add_test("press_kp5",          1, `PS2_CODE_KP5,   0, 8'h00,        0, 8, 1);
        add_test("press_kp6",          1, `PS2_CODE_KP6,   0, 8'h00,        0, 9, 1);
        // Break codes release one key only
        add_test("release_a",          2, `PS2_BREAK_CODE, 0, `PS2_CODE_A,   0, 2, 1'b0);
        add_test("w_still_set",        0, 8'h00,           0, 8'h00,        0, 1, 1);
        add_test("s_still_set",        0, 8'h00,           0, 8'h00,        0, 3, 1);
        add_test("release_kp5",        2, `PS2_BREAK_CODE, 0, `PS2_CODE_KP5, 0, 8, 0);
        add_test("kp4_still_set",      0, 8'h00,           0, 8'h00,        0, 7, 1);
        // Parity errors
        add_test("bad_parity_press_a", 1, `PS2_CODE_A,     1, 8'h00,        0, 2, 0);
        add_test("err_count_one",      0, 8'h00,           0, 8'h00,        0, 10, 1);
        add_test("break_then_bad_e",   2, `PS2_BREAK_CODE, 0, `PS2_CODE_E,   1, 0, 1);
        add_test("err_count_two",      0, 8'h00,           0, 8'h00,        0, 10, 2);
        add_test("armed_break_e",      1, `PS2_CODE_E,     0, 8'h00,        0, 0, 0);
        // Other keys
        add_test("non_game_code",      1, 8'h15,           0, 8'h00,        0, 0, 0);
        add_test("non_game_after_brk", 2, `PS2_BREAK_CODE, 0, 8'h15,        0, 1, 1);
        add_test("press_e_after_brk",  1, `PS2_CODE_E,     0, 8'h00,        0, 0, 1);
        add_test("err_count_kept",     0, 8'h00,           0, 8'h00,        0, 10, 2);
        for (int a = 11; a < 16; a++) begin
            add_test($sformatf("unmapped_addr_%0d", a), 0, 8'h00, 0, 8'h00, 0, 4'(a), 0);
        end
    endfunction

    task automatic run_entry(input int idx);
        entry_t e;
        e       = table_q[idx];
        test_ok = 1'b1;
        if (e.n_bytes >= 1) begin
            send_frame(e.byte0, e.bad0);
        end
        if (e.n_bytes >= 2) begin
            send_frame(e.byte1, e.bad1);
        end
        wait_cycles(8);
        check_read(name_q[idx], e.addr, e.expected);
        finish_test(name_q[idx]);
    endtask

    task automatic random_step(input int step);
        int    k;
        logic  press;
        string name;
        k       = $unsigned($random(seed)) % `PS2_KEY_COUNT;
        press   = 1'($random(seed));
        name    = $sformatf("random_%0d", step);
        test_ok = 1'b1;
        if (!press) begin
            send_frame(`PS2_BREAK_CODE, 1'b0);
        end
        send_frame(key_codes[k], 1'b0);
        ref_keys[k] = press;
        wait_cycles(8);
        for (int a = 0; a < `PS2_KEY_COUNT; a++) begin
            check_read(name, 4'(a), {31'd0, ref_keys[a]});
        end
        finish_test(name);
    endtask

    initial begin
        rst_n        = 1'b0;
        ps2_clk_pin  = 1'b1;
        ps2_data_pin = 1'b1;
        rd           = 1'b0;
        addr         = 4'd0;
        seed         = 25811;
        n_run        = 0;
        n_failed     = 0;
        test_ok      = 1'b1;
        ref_keys     = '0;
        key_codes    = '{`PS2_CODE_E, `PS2_CODE_W, `PS2_CODE_A, `PS2_CODE_S, `PS2_CODE_D,
                         `PS2_CODE_KP7, `PS2_CODE_KP8, `PS2_CODE_KP4, `PS2_CODE_KP5,
                         `PS2_CODE_KP6};
        build_table();
        table_ready = 1'b1;
        apply_reset();

        // Every mapped address reads zero out of reset
        test_ok = 1'b1;
        for (int a = 0; a <= `PS2_ERR_ADDR; a++) begin
            check_read("reset_reads", 4'(a), 32'd0);
        end
        finish_test("reset_reads");

        foreach (table_q[i]) begin
            run_entry(i);
        end

        // Fresh start so the reference array begins all released
        apply_reset();
        ref_keys = '0;
        for (int s = 0; s < RAND_STEPS; s++) begin
            random_step(s);
        end

        $display("Tests: %0d run, %0d passed, %0d failed", n_run, n_run - n_failed, n_failed);
        if (n_failed == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // Two frames of 11 bits at 16 clk cycles each per test, doubled for margin
    initial begin
        longint limit_ns;
        wait (table_ready);
        limit_ns = longint'(table_q.size() + RAND_STEPS + 1) * 2 * 11 * 16 * 10 * 2;
        #(limit_ns);
        $display("Timeout: the tests did not finish within %0d ns", limit_ns);
        $display(">>> FAIL");
        $finish;
    end

endmodule

//--- tb.f
+incdir+include
verilog/ps2_pkg.sv
verilog/ps2_sync.sv
verilog/ps2_frame_rx.sv
verilog/scan_filter.sv
verilog/key_state.sv
verilog/bus_read_port.sv
verilog/ps2_controller.sv
bench/ps2_controller_props.sv
bench/ps2_controller_tb.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and judge the result from the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM=ps2_controller_sim
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module ps2_controller_tb \
    --Mdir "$BUILD_DIR" -o "$SIM" \
    -f tb.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/$SIM" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^>>> PASS$" "$LOG"; then
    exit 0
fi
exit 1
